// File: common/sbus_pkg.sv
package sbus_pkg;

  // Data word and physical address widths
  localparam int word_bits = 36;
  localparam int pa_bits = 22;

  // Word index inside the internal memory, 1024 words
  localparam int mem_adr_bits = 10;

  // Address bits above the memory index, compared against the config base
  localparam int base_bits = pa_bits - mem_adr_bits;

  // Field positions in the diagnostic config word
  localparam int cfg_enable_bit = 0;
  localparam int cfg_force_par_bit = 1;
  localparam int cfg_base_lsb = 4;

  // Config after reset or memory reset
  localparam logic [base_bits-1:0] cfg_reset_base = '0;
  localparam logic cfg_reset_enable = 1'b1;

  // Request kinds decoded from the S bus levels
  typedef enum logic [1:0] {
    op_read,
    op_write,
    op_diag_read,
    op_diag_write
  } mem_op_e;

  // Memory controller states
  typedef enum logic [2:0] {
    st_idle,
    st_respond,
    st_read_words,
    st_write_words,
    st_diag_read
  } mem_state_e;

endpackage

// File: design/mt0_translator.sv
`timescale 1ns/1ps

// MBOX to S bus translator, one cable
module mt0_translator (
  input  logic                          sbus_clk,
  input  logic                          reset,

  // MBOX side
  input  logic [sbus_pkg::pa_bits-1:0]   pma,
  input  logic                          sbus_adr_hold,
  input  logic                          mem_adr_par,
  input  logic [3:0]                    mem_rq,
  input  logic                          mem_rd_rq,
  input  logic                          mem_wr_rq,
  input  logic                          mem_diag,
  input  logic                          mem_start_a,
  input  logic                          mem_start_b,
  input  logic                          mem_data_to_mem,
  input  logic [sbus_pkg::word_bits-1:0] mb,
  input  logic                          data_valid_a_out,
  input  logic                          data_valid_b_out,
  input  logic                          diag_mem_reset,
  output logic                          mem_ackn_a,
  output logic                          mem_ackn_b,
  output logic                          mem_adr_par_err,
  output logic                          mem_data_valid_a,
  output logic                          mem_data_valid_b,
  output logic [sbus_pkg::word_bits-1:0] mem_data_in,
  output logic                          mem_par_in,
  output logic                          mem_error,

  // S bus side
  output logic [sbus_pkg::pa_bits-1:0]   sbus_adr,
  output logic                          sbus_adr_par,
  output logic [3:0]                    sbus_rq,
  output logic                          sbus_rd_rq,
  output logic                          sbus_wr_rq,
  output logic                          sbus_diag,
  output logic                          sbus_start_a,
  output logic                          sbus_start_b,
  output logic                          sbus_mem_reset,
  output logic [sbus_pkg::word_bits-1:0] sbus_d_out,
  output logic                          sbus_data_par_out,
  output logic                          sbus_dv_a_out,
  output logic                          sbus_dv_b_out,
  input  logic                          sbus_ackn_a,
  input  logic                          sbus_ackn_b,
  input  logic                          sbus_adr_par_err,
  input  logic                          sbus_error,
  input  logic                          sbus_dv_a_in,
  input  logic                          sbus_dv_b_in,
  input  logic [sbus_pkg::word_bits-1:0] sbus_d_in,
  input  logic                          sbus_data_par_in
);

  logic par_mismatch;

  // Address hold register, loaded on every edge with hold high
  always_ff @(posedge sbus_clk) begin
    if (reset) begin
      sbus_adr <= '0;
    end else if (sbus_adr_hold) begin
      sbus_adr <= pma;
    end
  end

  // Request levels and starts go straight across
  assign sbus_adr_par   = mem_adr_par;
  assign sbus_rq        = mem_rq;
  assign sbus_rd_rq     = mem_rd_rq;
  assign sbus_wr_rq     = mem_wr_rq;
  assign sbus_diag      = mem_diag;
  assign sbus_start_a   = mem_start_a;
  assign sbus_start_b   = mem_start_b;
  assign sbus_mem_reset = diag_mem_reset;

  // Outbound direction, MBOX data and write strobes to memory
  assign sbus_d_out    = mem_data_to_mem ? mb : '0;
  assign sbus_dv_a_out = mem_data_to_mem & data_valid_a_out;
  assign sbus_dv_b_out = mem_data_to_mem & data_valid_b_out;

  // Even parity over the write word
  assign sbus_data_par_out = ^mb;

  // Inbound direction, strobes held low while driving toward memory
  assign mem_data_valid_a = ~mem_data_to_mem & sbus_dv_a_in;
  assign mem_data_valid_b = ~mem_data_to_mem & sbus_dv_b_in;
  assign mem_data_in      = sbus_d_in;
  assign mem_par_in       = sbus_data_par_in;

  // Acknowledge and address error back to MBOX
  assign mem_ackn_a      = sbus_ackn_a;
  assign mem_ackn_b      = sbus_ackn_b;
  assign mem_adr_par_err = sbus_adr_par_err;

  // Check returned parity only while a read word is on the bus
  assign par_mismatch = (mem_data_valid_a | mem_data_valid_b) &
                        ((^sbus_d_in) != sbus_data_par_in);
  assign mem_error    = par_mismatch | sbus_error;

  // MBOX starts one port at a time
  a_single_start: assert property (@(posedge sbus_clk) disable iff (reset)
    !(mem_start_a && mem_start_b));

endmodule

// File: design/sbus_top.sv
`timescale 1ns/1ps

module sbus_top (
  input  logic                           sbus_clk,
  input  logic                           reset,
  input  logic [sbus_pkg::pa_bits-1:0]   pma,
  input  logic                           sbus_adr_hold,
  input  logic                           mem_adr_par,
  input  logic [3:0]                     mem_rq,
  input  logic                           mem_rd_rq,
  input  logic                           mem_wr_rq,
  input  logic                           mem_diag,
  input  logic                           mem_start_a,
  input  logic                           mem_start_b,
  input  logic                           mem_data_to_mem,
  input  logic [sbus_pkg::word_bits-1:0] mb,
  input  logic                           data_valid_a_out,
  input  logic                           data_valid_b_out,
  input  logic                           diag_mem_reset,
  output logic                           mem_ackn_a,
  output logic                           mem_ackn_b,
  output logic                           mem_adr_par_err,
  output logic                           mem_data_valid_a,
  output logic                           mem_data_valid_b,
  output logic [sbus_pkg::word_bits-1:0] mem_data_in,
  output logic                           mem_par_in,
  output logic                           mem_error
);

  import sbus_pkg::*;

  // S bus between translator and memory
  logic [pa_bits-1:0]      sbus_adr;
  logic                    sbus_adr_par;
  logic [3:0]              sbus_rq;
  logic                    sbus_rd_rq;
  logic                    sbus_wr_rq;
  logic                    sbus_diag;
  logic                    sbus_start_a;
  logic                    sbus_start_b;
  logic                    sbus_mem_reset;
  logic [word_bits-1:0]    sbus_d_out;
  logic                    sbus_data_par_out;
  logic                    sbus_dv_a_out;
  logic                    sbus_dv_b_out;
  logic                    sbus_ackn_a;
  logic                    sbus_ackn_b;
  logic                    sbus_adr_par_err;
  logic                    sbus_error;
  logic                    sbus_dv_a_in;
  logic                    sbus_dv_b_in;
  logic [word_bits-1:0]    sbus_d_in;
  logic                    sbus_data_par_in;

  // Controller to config and array
  logic                    cfg_wr;
  logic [word_bits-1:0]    cfg_wdata;
  logic [word_bits-1:0]    cfg_word;
  logic [mem_adr_bits-1:0] arr_adr;
  logic                    arr_we;
  logic [word_bits-1:0]    arr_wdata;
  logic                    arr_wpar;
  logic [word_bits-1:0]    arr_rdata;
  logic                    arr_rpar;

  mt0_translator u_mt0 (.*);

  mem_ctrl u_ctrl (.*);

  mem_array u_array (.*);

  mem_config_regs u_cfg (.*);

endmodule

// File: memory/mem_array.sv
`timescale 1ns/1ps

module mem_array (
  input  logic                              sbus_clk,
  input  logic [sbus_pkg::mem_adr_bits-1:0] arr_adr,
  input  logic                              arr_we,
  input  logic [sbus_pkg::word_bits-1:0]    arr_wdata,
  input  logic                              arr_wpar,
  output logic [sbus_pkg::word_bits-1:0]    arr_rdata,
  output logic                              arr_rpar
);

  import sbus_pkg::*;

  localparam int depth = 2 ** mem_adr_bits;

  // Each entry is the data word with its parity bit on top
  logic [word_bits:0] mem [depth];

  logic [word_bits:0] rd_q;

  // Write port
  always_ff @(posedge sbus_clk) begin
    if (arr_we) begin
      mem[arr_adr] <= {arr_wpar, arr_wdata};
    end
  end

  // Registered read, old contents on a same-cycle write
  always_ff @(posedge sbus_clk) begin
    rd_q <= mem[arr_adr];
  end

  assign arr_rdata = rd_q[word_bits-1:0];
  assign arr_rpar  = rd_q[word_bits];

endmodule

// File: memory/mem_config_regs.sv
`timescale 1ns/1ps

module mem_config_regs (
  input  logic                           sbus_clk,
  input  logic                           reset,
  input  logic                           sbus_mem_reset,
  input  logic                           cfg_wr,
  input  logic [sbus_pkg::word_bits-1:0] cfg_wdata,
  output logic [sbus_pkg::word_bits-1:0] cfg_word
);

  import sbus_pkg::*;

  logic                 enable_q;
  logic                 force_par_q;
  logic [base_bits-1:0] base_q;

  // Fields load from a diag write word in the same positions they read back
  always_ff @(posedge sbus_clk) begin
    if (reset || sbus_mem_reset) begin
      enable_q    <= cfg_reset_enable;
      force_par_q <= 1'b0;
      base_q      <= cfg_reset_base;
    end else if (cfg_wr) begin
      enable_q    <= cfg_wdata[cfg_enable_bit];
      force_par_q <= cfg_wdata[cfg_force_par_bit];
      base_q      <= cfg_wdata[cfg_base_lsb +: base_bits];
    end
  end

  // Pack fields, unused bits read as zero
  always_comb begin
    cfg_word                              = '0;
    cfg_word[cfg_enable_bit]              = enable_q;
    cfg_word[cfg_force_par_bit]           = force_par_q;
    cfg_word[cfg_base_lsb +: base_bits]   = base_q;
  end

endmodule

// File: memory/mem_ctrl.sv
`timescale 1ns/1ps

module mem_ctrl (
  input  logic                                     sbus_clk,
  input  logic                                     reset,
  input  logic [sbus_pkg::pa_bits-1:0]              sbus_adr,
  input  logic                                     sbus_adr_par,
  input  logic [3:0]                               sbus_rq,
  input  logic                                     sbus_rd_rq,
  input  logic                                     sbus_wr_rq,
  input  logic                                     sbus_diag,
  input  logic                                     sbus_start_a,
  input  logic                                     sbus_start_b,
  input  logic                                     sbus_mem_reset,
  input  logic [sbus_pkg::word_bits-1:0]            sbus_d_out,
  input  logic                                     sbus_data_par_out,
  input  logic                                     sbus_dv_a_out,
  input  logic                                     sbus_dv_b_out,
  output logic                                     sbus_ackn_a,
  output logic                                     sbus_ackn_b,
  output logic                                     sbus_adr_par_err,
  output logic                                     sbus_error,
  output logic                                     sbus_dv_a_in,
  output logic                                     sbus_dv_b_in,
  output logic [sbus_pkg::word_bits-1:0]            sbus_d_in,
  output logic                                     sbus_data_par_in,
  input  logic [sbus_pkg::word_bits-1:0]            cfg_word,
  output logic                                     cfg_wr,
  output logic [sbus_pkg::word_bits-1:0]            cfg_wdata,
  output logic [sbus_pkg::mem_adr_bits-1:0]         arr_adr,
  output logic                                     arr_we,
  output logic [sbus_pkg::word_bits-1:0]            arr_wdata,
  output logic                                     arr_wpar,
  input  logic [sbus_pkg::word_bits-1:0]            arr_rdata,
  input  logic                                     arr_rpar
);

  import sbus_pkg::*;

  mem_state_e                state;
  mem_op_e                   req_op;
  mem_op_e                   op_q;
  logic                      ctrl_reset;
  logic                      start;
  logic                      req_valid;
  logic                      adr_par_ok;
  logic                      hit;
  logic                      port_b_q;
  logic                      src_cfg_q;
  logic [mem_adr_bits-3:0]   qw_q;
  logic [1:0]                ptr_q;
  logic [3:0]                left_q;
  logic [3:0]                left_next;
  logic [1:0]                first_word;
  logic                      wr_stb;
  logic                      step;

  // First masked word at or after a start position, wrapping in the quadword
  function automatic logic [1:0] next_word(input logic [1:0] from, input logic [3:0] mask);
    logic [1:0] w;
    next_word = from;
    // Search downward so the nearest set bit wins
    for (int i = 3; i >= 0; i--) begin
      w = from + 2'(i);
      if (mask[w]) begin
        next_word = w;
      end
    end
  endfunction

  // Memory reset acts like reset on this block
  assign ctrl_reset = reset | sbus_mem_reset;

  assign start     = sbus_start_a | sbus_start_b;
  assign req_valid = sbus_rd_rq | sbus_wr_rq;

  always_comb begin
    if (sbus_diag) begin
      req_op = sbus_wr_rq ? op_diag_write : op_diag_read;
    end else begin
      req_op = sbus_wr_rq ? op_write : op_read;
    end
  end

  // Address is checked the cycle after start, once the hold register has it
  assign adr_par_ok = ^{sbus_adr, sbus_adr_par};

  // Diag cycles are always answered so a disabled memory can be set up again
  assign hit = (op_q == op_diag_read) || (op_q == op_diag_write) ||
               (cfg_word[cfg_enable_bit] &&
                sbus_adr[pa_bits-1:mem_adr_bits] == cfg_word[cfg_base_lsb +: base_bits]);

  assign first_word = next_word(sbus_adr[1:0], sbus_rq);
  assign left_next  = left_q & ~(4'b0001 << ptr_q);

  // Write strobes count only on the port that started
  assign wr_stb = port_b_q ? sbus_dv_b_out : sbus_dv_a_out;

  assign step = (state == st_read_words) ||
                (state == st_write_words && wr_stb && op_q == op_write);

  always_ff @(posedge sbus_clk) begin
    if (ctrl_reset) begin
      state            <= st_idle;
      sbus_ackn_a      <= 1'b0;
      sbus_ackn_b      <= 1'b0;
      sbus_adr_par_err <= 1'b0;
      sbus_dv_a_in     <= 1'b0;
      sbus_dv_b_in     <= 1'b0;
      src_cfg_q        <= 1'b0;
    end else begin
      // Responses are single cycle pulses
      sbus_ackn_a      <= 1'b0;
      sbus_ackn_b      <= 1'b0;
      sbus_adr_par_err <= 1'b0;
      sbus_dv_a_in     <= 1'b0;
      sbus_dv_b_in     <= 1'b0;
      case (state)
        st_idle: begin
          if (start && req_valid) begin
            state <= st_respond;
          end
        end
        st_respond: begin
          if (!adr_par_ok) begin
            sbus_adr_par_err <= 1'b1;
            state            <= st_idle;
          end else if (!hit) begin
            // Out of range, stay silent
            state <= st_idle;
          end else begin
            sbus_ackn_a <= ~port_b_q;
            sbus_ackn_b <= port_b_q;
            src_cfg_q   <= (op_q == op_diag_read);
            case (op_q)
              op_read:       state <= (sbus_rq == 4'b0) ? st_idle : st_read_words;
              op_write:      state <= (sbus_rq == 4'b0) ? st_idle : st_write_words;
              op_diag_read:  state <= st_diag_read;
              default:       state <= st_write_words;
            endcase
          end
        end
        st_read_words: begin
          // Array word for ptr_q lands together with this strobe
          sbus_dv_a_in <= ~port_b_q;
          sbus_dv_b_in <= port_b_q;
          if (left_next == 4'b0) begin
            state <= st_idle;
          end
        end
        st_diag_read: begin
          sbus_dv_a_in <= ~port_b_q;
          sbus_dv_b_in <= port_b_q;
          state        <= st_idle;
        end
        st_write_words: begin
          if (wr_stb && (op_q == op_diag_write || left_next == 4'b0)) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Request payload and the word pointer
  always_ff @(posedge sbus_clk) begin
    if (state == st_idle && start) begin
      op_q     <= req_op;
      port_b_q <= sbus_start_b;
    end
    if (state == st_respond) begin
      qw_q   <= sbus_adr[mem_adr_bits-1:2];
      ptr_q  <= first_word;
      left_q <= sbus_rq;
    end else if (step) begin
      ptr_q  <= next_word(ptr_q + 2'd1, left_next);
      left_q <= left_next;
    end
  end

  // Array port, read address leads the strobe by one cycle
  assign arr_adr   = {qw_q, ptr_q};
  assign arr_we    = (state == st_write_words) && wr_stb && (op_q == op_write);
  assign arr_wdata = sbus_d_out;
  assign arr_wpar  = sbus_data_par_out ^ cfg_word[cfg_force_par_bit];

  // Config write from a diag write strobe
  assign cfg_wr    = (state == st_write_words) && wr_stb && (op_q == op_diag_write);
  assign cfg_wdata = sbus_d_out;

  // Read data from the array or the config word
  assign sbus_d_in        = src_cfg_q ? cfg_word : arr_rdata;
  assign sbus_data_par_in = src_cfg_q ? ^cfg_word : arr_rpar;

  // No internal fault sources here
  assign sbus_error = 1'b0;

  // Acknowledge excludes the address error and lasts one cycle
  a_ack_pulse: assert property (@(posedge sbus_clk) disable iff (ctrl_reset)
    (sbus_ackn_a || sbus_ackn_b) |-> !sbus_adr_par_err ##1 !(sbus_ackn_a || sbus_ackn_b));

  // A read strobe is never issued from idle
  a_no_idle_strobe: assert property (@(posedge sbus_clk) disable iff (ctrl_reset)
    (sbus_dv_a_in || sbus_dv_b_in) |-> $past(state) != st_idle);

endmodule

// File: project.f
common/sbus_pkg.sv
design/mt0_translator.sv
memory/mem_ctrl.sv
memory/mem_array.sv
memory/mem_config_regs.sv
design/sbus_top.sv
test/sbus_checker.sv
test/tb_sbus.sv

// File: test/sbus_checker.sv
`timescale 1ns/1ps

module sbus_checker (
  input  logic                           sbus_clk,
  input  logic                           reset,
  input  logic                           mem_ackn_a,
  input  logic                           mem_ackn_b,
  input  logic                           mem_adr_par_err,
  input  logic                           mem_data_valid_a,
  input  logic                           mem_data_valid_b,
  input  logic [sbus_pkg::word_bits-1:0] mem_data_in,
  input  logic                           mem_par_in,
  input  logic                           mem_error
);

  import sbus_pkg::*;

  // One expected entry per cycle, taken at the falling edge
  // Layout {ack_a, ack_b, par_err, dv_a, dv_b, error, parity, data}
  logic [word_bits+6:0] exp_q [$];
  logic [word_bits+6:0] cur;

  int total_errors = 0;
  int test_errors  = 0;
  int tests_run    = 0;
  int tests_failed = 0;

  task automatic push_expect(input logic [word_bits+6:0] vec);
    exp_q.push_back(vec);
  endtask

  function automatic int pending_count();
    return exp_q.size();
  endfunction

  task automatic compare(input string name, input logic [word_bits-1:0] exp_val,
                         input logic [word_bits-1:0] got);
    if (got !== exp_val) begin
      $display("ERROR at time %0t: %s expected %0h, got %0h", $time, name, exp_val, got);
      total_errors++;
      test_errors++;
    end
  endtask

  // Mid-cycle sample with all outputs settled
  always @(negedge sbus_clk) begin
    if (!reset) begin
      // Nothing queued means the bus must be quiet
      cur = '0;
      if (exp_q.size() > 0) begin
        cur = exp_q.pop_front();
      end
      compare("mem_ackn_a", cur[word_bits+6], mem_ackn_a);
      compare("mem_ackn_b", cur[word_bits+5], mem_ackn_b);
      compare("mem_adr_par_err", cur[word_bits+4], mem_adr_par_err);
      compare("mem_data_valid_a", cur[word_bits+3], mem_data_valid_a);
      compare("mem_data_valid_b", cur[word_bits+2], mem_data_valid_b);
      compare("mem_error", cur[word_bits+1], mem_error);
      // Data and parity only under a strobe
      if (cur[word_bits+3] || cur[word_bits+2]) begin
        compare("mem_data_in", cur[word_bits-1:0], mem_data_in);
        compare("mem_par_in", cur[word_bits], mem_par_in);
      end
    end
  end

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d, %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d, %s: failed with %0d mismatches", tests_run, name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic print_summary();
    $display("%0d tests run, %0d passed, %0d failed, %0d mismatches in total",
             tests_run, tests_run - tests_failed, tests_failed, total_errors);
  endtask

endmodule

// File: test/tb_sbus.sv
`timescale 1ns/1ps

module tb_sbus;

  import sbus_pkg::*;

  localparam int clk_period     = 40;
  localparam int drive_dly      = 2;
  localparam int reset_cycles   = 4;
  localparam int pairs_any_port = 8;
  localparam int pairs_port_b   = 4;
  localparam int max_gap        = 3;
  localparam int miss_window    = 6;
  // Worst request is start, ack, four words behind the widest gap, then drain
  localparam int req_worst   = 4 + 4 * (max_gap + 1) + 2;
  localparam int n_requests  = 1 + 2 * (pairs_any_port + pairs_port_b) + 4 + 8 + 6;
  localparam int cycle_limit = 2 * (reset_cycles + n_requests * req_worst + 4);

  logic                 sbus_clk;
  logic                 reset;
  logic [pa_bits-1:0]   pma;
  logic                 sbus_adr_hold;
  logic                 mem_adr_par;
  logic [3:0]           mem_rq;
  logic                 mem_rd_rq, mem_wr_rq, mem_diag;
  logic                 mem_start_a, mem_start_b;
  logic                 mem_data_to_mem;
  logic [word_bits-1:0] mb;
  logic                 data_valid_a_out, data_valid_b_out;
  logic                 diag_mem_reset;
  logic                 mem_ackn_a, mem_ackn_b;
  logic                 mem_adr_par_err;
  logic                 mem_data_valid_a, mem_data_valid_b;
  logic [word_bits-1:0] mem_data_in;
  logic                 mem_par_in;
  logic                 mem_error;

  // Reference memory words with parity on top, plus the config fields
  logic [word_bits:0]   model_mem [int];
  logic                 model_enable;
  logic                 model_force;
  logic [base_bits-1:0] model_base;
  int                   cycles;

  sbus_top dut (.*);

  sbus_checker u_checker (.*);

  initial begin
    sbus_clk = 1'b0;
    forever #(clk_period / 2) sbus_clk = ~sbus_clk;
  end

  // Run limit
  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge sbus_clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
    $display("tests failed");
    $finish;
  end

  function automatic logic [word_bits-1:0] model_cfg_word();
    logic [word_bits-1:0] w;
    w = '0;
    w[cfg_enable_bit] = model_enable;
    w[cfg_force_par_bit] = model_force;
    w[cfg_base_lsb +: base_bits] = model_base;
    return w;
  endfunction

  function automatic logic [pa_bits-1:0] rand_adr(input logic [base_bits-1:0] base);
    logic [31:0] r;
    r = $urandom;
    return {base, r[mem_adr_bits-1:0]};
  endfunction

  function automatic logic [word_bits-1:0] rand_word();
    logic [63:0] r;
    r = {$urandom, $urandom};
    return r[word_bits-1:0];
  endfunction

  // Word slot inside the memory, base bits dropped
  function automatic int word_index(input logic [pa_bits-1:0] adr, input logic [1:0] w);
    return int'({adr[mem_adr_bits-1:2], w});
  endfunction

  task automatic next_cycle();
    @(posedge sbus_clk);
    #drive_dly;
  endtask

  task automatic drain();
    while (u_checker.pending_count() > 0) @(posedge sbus_clk);
    #drive_dly;
  endtask

  task automatic expect_quiet(input int n);
    repeat (n) u_checker.push_expect('0);
  endtask

  task automatic expect_ack(input logic port_b);
    u_checker.push_expect({~port_b, port_b, 5'b0, {word_bits{1'b0}}});
  endtask

  task automatic expect_par_err();
    u_checker.push_expect({3'b001, 4'b0, {word_bits{1'b0}}});
  endtask

  // Error flag whenever stored parity disagrees with the data
  task automatic expect_word(input logic port_b, input logic [word_bits:0] word);
    u_checker.push_expect({3'b000, ~port_b, port_b,
                           (^word[word_bits-1:0]) != word[word_bits], word});
  endtask

  task automatic release_bus();
    sbus_adr_hold = 1'b0;
    mem_rq = '0;
    mem_rd_rq = 1'b0;
    mem_wr_rq = 1'b0;
    mem_diag = 1'b0;
    mem_data_to_mem = 1'b0;
    data_valid_a_out = 1'b0;
    data_valid_b_out = 1'b0;
  endtask

  // Levels go up with a one-cycle start, returns in cycle 0
  task automatic start_request(input logic [pa_bits-1:0] adr, input logic good_par,
                               input logic [3:0] mask, input mem_op_e op,
                               input logic port_b);
    drain();
    next_cycle();
    pma = adr;
    sbus_adr_hold = 1'b1;
    mem_adr_par = good_par ? ~^adr : ^adr;
    mem_rq = mask;
    mem_rd_rq = (op == op_read) || (op == op_diag_read);
    mem_wr_rq = (op == op_write) || (op == op_diag_write);
    mem_diag = (op == op_diag_read) || (op == op_diag_write);
    mem_data_to_mem = mem_wr_rq;
    mem_start_a = ~port_b;
    mem_start_b = port_b;
    expect_quiet(2);
    next_cycle();
    mem_start_a = 1'b0;
    mem_start_b = 1'b0;
  endtask

  // Handshake for the data phase, bounded to a few cycles
  task automatic wait_ack(input logic port_b, output logic seen);
    seen = 1'b0;
    for (int k = 0; k < 3 && !seen; k++) begin
      @(negedge sbus_clk);
      seen = port_b ? mem_ackn_b : mem_ackn_a;
    end
    next_cycle();
  endtask

  task automatic write_quad(input logic [pa_bits-1:0] adr, input logic [3:0] mask,
                            input logic port_b);
    logic                 seen;
    logic [1:0]           w;
    logic [word_bits-1:0] data;
    int                   gap;
    start_request(adr, 1'b1, mask, op_write, port_b);
    expect_ack(port_b);
    wait_ack(port_b, seen);
    if (seen) begin
      // Masked words in wrap order from the addressed word
      for (int j = 0; j < 4; j++) begin
        w = adr[1:0] + 2'(j);
        if (mask[w]) begin
          gap = $urandom_range(max_gap, 0);
          repeat (gap) next_cycle();
          data = rand_word();
          mb = data;
          data_valid_a_out = ~port_b;
          data_valid_b_out = port_b;
          model_mem[word_index(adr, w)] = {(^data) ^ model_force, data};
          next_cycle();
          data_valid_a_out = 1'b0;
          data_valid_b_out = 1'b0;
        end
      end
    end
    release_bus();
  endtask

  task automatic read_quad(input logic [pa_bits-1:0] adr, input logic [3:0] mask,
                           input logic port_b);
    logic [1:0] w;
    start_request(adr, 1'b1, mask, op_read, port_b);
    expect_ack(port_b);
    for (int j = 0; j < 4; j++) begin
      w = adr[1:0] + 2'(j);
      if (mask[w]) begin
        expect_word(port_b, model_mem[word_index(adr, w)]);
      end
    end
    drain();
    release_bus();
  endtask

  // Miss gets no answer at all
  task automatic read_missed(input logic [pa_bits-1:0] adr);
    start_request(adr, 1'b1, 4'hf, op_read, 1'b0);
    expect_quiet(miss_window);
    drain();
    release_bus();
  endtask

  // Junk strobes after a bad address must not reach the array
  task automatic bad_parity(input logic [pa_bits-1:0] adr, input mem_op_e op);
    start_request(adr, 1'b0, 4'hf, op, 1'b0);
    expect_par_err();
    expect_quiet(3);
    if (op == op_write) begin
      next_cycle();
      mb = rand_word();
      data_valid_a_out = 1'b1;
      repeat (3) next_cycle();
      data_valid_a_out = 1'b0;
    end
    drain();
    release_bus();
  endtask

  task automatic diag_write(input logic enable, input logic force_par,
                            input logic [base_bits-1:0] base);
    logic seen;
    start_request('0, 1'b1, 4'h0, op_diag_write, 1'b0);
    expect_ack(1'b0);
    wait_ack(1'b0, seen);
    if (seen) begin
      model_enable = enable;
      model_force = force_par;
      model_base = base;
      mb = model_cfg_word();
      data_valid_a_out = 1'b1;
      next_cycle();
      data_valid_a_out = 1'b0;
    end
    release_bus();
  endtask

  // Config word comes back with even parity
  task automatic diag_read();
    start_request('0, 1'b1, 4'h0, op_diag_read, 1'b0);
    expect_ack(1'b0);
    expect_word(1'b0, {^model_cfg_word(), model_cfg_word()});
    drain();
    release_bus();
  endtask

  task automatic pulse_mem_reset();
    next_cycle();
    diag_mem_reset = 1'b1;
    next_cycle();
    diag_mem_reset = 1'b0;
    // Base 0 and enabled again
    model_enable = 1'b1;
    model_force = 1'b0;
    model_base = '0;
  endtask

  task automatic write_read_pairs(input int n, input logic only_b);
    logic [pa_bits-1:0] adr;
    logic [3:0]         mask;
    logic               port_b;
    int unsigned        r;
    for (int i = 0; i < n; i++) begin
      adr = rand_adr(model_base);
      r = $urandom_range(15, 1);
      mask = r[3:0];
      r = $urandom;
      port_b = only_b | r[0];
      write_quad(adr, mask, port_b);
      read_quad(adr, mask, port_b);
    end
  endtask

  initial begin
    logic [pa_bits-1:0]   adr;
    logic [pa_bits-1:0]   clean_adr;
    logic [base_bits-1:0] new_base;
    int unsigned          r;
    // One seed for the whole run
    void'($urandom(32'h2f88));
    reset = 1'b1;
    pma = '0;
    mem_adr_par = 1'b0;
    mem_start_a = 1'b0;
    mem_start_b = 1'b0;
    mb = '0;
    diag_mem_reset = 1'b0;
    release_bus();
    model_enable = 1'b1;
    model_force = 1'b0;
    model_base = '0;
    repeat (reset_cycles) @(posedge sbus_clk);
    #drive_dly;
    reset = 1'b0;

    // Quiet outputs, then the reset config word
    diag_read();
    u_checker.finish_test("reset state");

    write_read_pairs(pairs_any_port, 1'b0);
    u_checker.finish_test("writes then reads");

    write_read_pairs(pairs_port_b, 1'b1);
    u_checker.finish_test("port B selection");

    adr = rand_adr(model_base);
    write_quad(adr, 4'hf, 1'b0);
    bad_parity(adr, op_write);
    bad_parity(adr, op_read);
    read_quad(adr, 4'hf, 1'b0);
    u_checker.finish_test("address parity");

    // Move the base, then disable, then restore by memory reset
    adr = rand_adr('0);
    write_quad(adr, 4'hf, 1'b0);
    r = $urandom_range(4095, 1);
    new_base = r[base_bits-1:0];
    diag_write(1'b1, 1'b0, new_base);
    read_missed(adr);
    read_quad({new_base, adr[mem_adr_bits-1:0]}, 4'hf, 1'b1);
    diag_write(1'b0, 1'b0, new_base);
    read_missed({new_base, adr[mem_adr_bits-1:0]});
    diag_read();
    pulse_mem_reset();
    read_quad(adr, 4'hf, 1'b0);
    u_checker.finish_test("config range");

    // Word written before force stays clean
    clean_adr = rand_adr('0);
    write_quad(clean_adr, 4'hf, 1'b0);
    diag_write(1'b1, 1'b1, '0);
    adr = rand_adr('0);
    while (adr[mem_adr_bits-1:2] == clean_adr[mem_adr_bits-1:2]) begin
      adr = rand_adr('0);
    end
    write_quad(adr, 4'hf, 1'b1);
    read_quad(adr, 4'hf, 1'b1);
    read_quad(clean_adr, 4'hf, 1'b0);
    diag_write(1'b1, 1'b0, '0);
    u_checker.finish_test("forced parity");

    u_checker.print_summary();
    if (u_checker.total_errors == 0 && u_checker.tests_failed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
